/* testbench/program.hex */
// one instruction word per line, ROM word 0 at 0x40000000 first
// the text after each word is its assembly
0000308B // in    x1, x0        mode
01000F93 // addi  x31, x0, 16   result port
10009C63 // bne   x1, x0, +280  to the misaligned load
06400113 // addi  x2, x0, 100
FF900193 // addi  x3, x0, -7
00300293 // addi  x5, x0, 3
00400F13 // addi  x30, x0, 4    random input port
00310233 // add   x4, x2, x3
004FC00B // out   x31, x4
40310233 // sub   x4, x2, x3
004FC00B // out   x31, x4
00314233 // xor   x4, x2, x3
004FC00B // out   x31, x4
FF916213 // ori   x4, x2, -7
004FC00B // out   x31, x4
FF917213 // andi  x4, x2, -7
004FC00B // out   x31, x4
00511233 // sll   x4, x2, x5
004FC00B // out   x31, x4
0041D213 // srli  x4, x3, 4
004FC00B // out   x31, x4
4011D213 // srai  x4, x3, 1
004FC00B // out   x31, x4
0021A233 // slt   x4, x3, x2
004FC00B // out   x31, x4
0021B233 // sltu  x4, x3, x2
004FC00B // out   x31, x4
FFF13213 // sltiu x4, x2, -1
004FC00B // out   x31, x4
FFF12213 // slti  x4, x2, -1
004FC00B // out   x31, x4
00210463 // beq   x2, x2, +8
000FC00B // out   x31, x0       skipped
0021C463 // blt   x3, x2, +8
000FC00B // out   x31, x0       skipped
0021F463 // bgeu  x3, x2, +8
000FC00B // out   x31, x0       skipped
00211463 // bne   x2, x2, +8    not taken
002FC00B // out   x31, x2
00C0036F // jal   x6, +12
007FC00B // out   x31, x7
00C0006F // jal   x0, +12
006FC00B // out   x31, x6
000303E7 // jalr  x7, 0(x6)
80000437 // lui   x8, 0x80000   RAM base
876544B7 // lui   x9, 0x87654
32148493 // addi  x9, x9, 0x321
00942023 // sw    x9, 0(x8)
00942223 // sw    x9, 4(x8)
00341323 // sh    x3, 6(x8)
002400A3 // sb    x2, 1(x8)
00340503 // lb    x10, 3(x8)
00AFC00B // out   x31, x10
00344503 // lbu   x10, 3(x8)
00AFC00B // out   x31, x10
00140503 // lb    x10, 1(x8)
00AFC00B // out   x31, x10
00641503 // lh    x10, 6(x8)
00AFC00B // out   x31, x10
00645503 // lhu   x10, 6(x8)
00AFC00B // out   x31, x10
00042503 // lw    x10, 0(x8)
00AFC00B // out   x31, x10
00442503 // lw    x10, 4(x8)
00AFC00B // out   x31, x10
000F358B // in    x11, x30
00158593 // addi  x11, x11, 1
00BFC00B // out   x31, x11
000F358B // in    x11, x30
00158593 // addi  x11, x11, 1
00BFC00B // out   x31, x11
0000200B // hlt
80000637 // lui   x12, 0x80000
00262683 // lw    x13, 2(x12)   misaligned
0000200B // hlt

/* sources.f */
design/tiny32_pkg.sv
design/tiny32_decoder.sv
design/tiny32_alu.sv
design/tiny32_regfile.sv
design/tiny32_ram_lane.sv
design/tiny32_mem.sv
design/tiny32_control.sv
design/tiny32.sv
testbench/tiny32_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tiny32_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tiny32_tb.sv */
`timescale 1ns/1ps

module tiny32_tb;
    import tiny32_pkg::*;

    localparam int main_rows = 27;
    localparam int num_rows = main_rows + 1;
    localparam int mode_row = main_rows;
    localparam int watchdog_cycles = 200 * num_rows + 500;

    typedef enum logic [1:0] {
        row_in,
        row_out,
        row_in_random,
        row_out_echo
    } row_kind_t;

    typedef struct packed {
        row_kind_t kind;
        word_t     addr;
        word_t     data;
    } io_row_t;

    logic    clk;
    logic    nreset;
    logic    hlt;
    logic    error;
    word_t   io_address;
    word_t   io_data_in;
    word_t   io_data_out;
    logic    io_req;
    logic    io_nwr;
    logic    io_ready;
    word_t   lfsr;
    word_t   last_in;
    io_row_t rows [num_rows];

    tiny32 tiny32_i (
        .clk(clk),
        .nreset(nreset),
        .hlt(hlt),
        .error(error),
        .io_address(io_address),
        .io_data_in(io_data_in),
        .io_data_out(io_data_out),
        .io_req(io_req),
        .io_nwr(io_nwr),
        .io_ready(io_ready)
    );

    always #4 clk = ~clk;

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            stop_on_failure($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h",
                                      name, got, expected));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            stop_on_failure($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h",
                                      name, got, expected));
        end
    endtask

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic word_t lfsr_next(input word_t s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic random_bits(input int count, output word_t bits);
        int i;
        bits = '0;
        for (i = 0; i < count; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    task automatic apply_reset();
        nreset = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        nreset = 1'b1;
        check_flag("hlt", hlt, 1'b0);
        check_flag("error", error, 1'b0);
        check_flag("io_req", io_req, 1'b0);
    endtask

    task automatic wait_for_io_req();
        do begin
            @(posedge clk);
            #1;
            if (error) begin
                stop_on_failure("error raised while an io request was still expected");
            end
            if (hlt) begin
                stop_on_failure("core halted while an io request was still expected");
            end
        end while (!io_req);
    endtask

    // one io transaction with a random number of ready wait cycles
    task automatic serve_row(input io_row_t row);
        word_t delay;
        word_t reply;
        wait_for_io_req();
        check_flag("io_nwr", io_nwr, row.kind == row_in || row.kind == row_in_random);
        check_word("io_address", io_address, row.addr);
        if (row.kind == row_out) begin
            check_word("io_data_out", io_data_out, row.data);
        end else if (row.kind == row_out_echo) begin
            check_word("io_data_out", io_data_out, last_in + 32'd1);
        end
        reply = (row.kind == row_in) ? row.data : '0;
        if (row.kind == row_in_random) begin
            random_bits(32, reply);
            last_in = reply;
        end
        random_bits(2, delay);
        repeat (delay) begin
            @(posedge clk);
            #1;
            check_flag("io_req", io_req, 1'b1);
        end
        io_ready = 1'b1;
        io_data_in = reply;
        @(posedge clk);
        #1;
        io_ready = 1'b0;
        io_data_in = '0;
        check_flag("io_req", io_req, 1'b0);
    endtask

    task automatic wait_for_stop();
        do begin
            @(posedge clk);
            #1;
            if (io_req) begin
                stop_on_failure("io request seen after the last expected transaction");
            end
        end while (!hlt && !error);
    endtask

    task automatic watch_quiet(input int cycles, input logic hlt_exp, input logic error_exp);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            check_flag("io_req", io_req, 1'b0);
            check_flag("hlt", hlt, hlt_exp);
            check_flag("error", error, error_exp);
        end
    endtask

    // port 16 takes results, port 4 gives random values, port 0 gives the mode
    task automatic fill_table();
        rows[0] = '{row_in, 32'h0, 32'h0};
        rows[1] = '{row_out, 32'h10, 32'h0000005d};
        rows[2] = '{row_out, 32'h10, 32'h0000006b};
        rows[3] = '{row_out, 32'h10, 32'hffffff9d};
        rows[4] = '{row_out, 32'h10, 32'hfffffffd};
        rows[5] = '{row_out, 32'h10, 32'h00000060};
        rows[6] = '{row_out, 32'h10, 32'h00000320};
        rows[7] = '{row_out, 32'h10, 32'h0fffffff};
        rows[8] = '{row_out, 32'h10, 32'hfffffffc};
        rows[9] = '{row_out, 32'h10, 32'h00000001};
        rows[10] = '{row_out, 32'h10, 32'h00000000};
        rows[11] = '{row_out, 32'h10, 32'h00000001};
        rows[12] = '{row_out, 32'h10, 32'h00000000};
        // not-taken bne lets this one through
        rows[13] = '{row_out, 32'h10, 32'h00000064};
        // jal and jalr links
        rows[14] = '{row_out, 32'h10, 32'h400000a0};
        rows[15] = '{row_out, 32'h10, 32'h400000b0};
        rows[16] = '{row_out, 32'h10, 32'hffffff87};
        rows[17] = '{row_out, 32'h10, 32'h00000087};
        rows[18] = '{row_out, 32'h10, 32'h00000064};
        rows[19] = '{row_out, 32'h10, 32'hfffffff9};
        rows[20] = '{row_out, 32'h10, 32'h0000fff9};
        rows[21] = '{row_out, 32'h10, 32'h87656421};
        rows[22] = '{row_out, 32'h10, 32'hfff94321};
        rows[23] = '{row_in_random, 32'h4, 32'h0};
        rows[24] = '{row_out_echo, 32'h10, 32'h0};
        rows[25] = '{row_in_random, 32'h4, 32'h0};
        rows[26] = '{row_out_echo, 32'h10, 32'h0};
        // second run selects the misaligned load
        rows[mode_row] = '{row_in, 32'h0, 32'h1};
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        stop_on_failure("watchdog expired before the test sequence finished");
    end

    initial begin
        int r;
        clk = 1'b0;
        nreset = 1'b0;
        io_ready = 1'b0;
        io_data_in = '0;
        lfsr = 32'h4ac5;
        last_in = '0;
        fill_table();

        apply_reset();
        for (r = 0; r < main_rows; r++) begin
            serve_row(rows[r]);
        end
        wait_for_stop();
        check_flag("hlt", hlt, 1'b1);
        check_flag("error", error, 1'b0);
        watch_quiet(50, 1'b1, 1'b0);

        apply_reset();
        serve_row(rows[mode_row]);
        wait_for_stop();
        check_flag("error", error, 1'b1);
        check_flag("hlt", hlt, 1'b0);
        watch_quiet(50, 1'b0, 1'b1);

        $display("sim passed");
        $finish;
    end

endmodule

/* design/tiny32.sv */
`timescale 1ns/1ps

module tiny32 (
    input  logic              clk,
    input  logic              nreset,
    output logic              hlt,
    output logic              error,
    output tiny32_pkg::word_t io_address,
    input  tiny32_pkg::word_t io_data_in,
    output tiny32_pkg::word_t io_data_out,
    output logic              io_req,
    output logic              io_nwr,
    input  logic              io_ready
);
    import tiny32_pkg::*;

    word_t    instr;
    word_t    pc;
    word_t    rs_data1;
    word_t    rs_data2;
    word_t    rf_wdata;
    word_t    alu_result;
    word_t    target;
    word_t    mem_rdata;
    decoded_t dec;
    reg_idx_t rf_rd;
    mem_req_t mem_req;
    logic     rf_we;
    logic     take_branch;
    logic     mem_fault;

    tiny32_control control_i (
        .clk(clk),
        .nreset(nreset),
        .instr_dec(dec),
        .instr(instr),
        .rs_data1(rs_data1),
        .rs_data2(rs_data2),
        .rf_we(rf_we),
        .rf_rd(rf_rd),
        .rf_wdata(rf_wdata),
        .alu_result(alu_result),
        .take_branch(take_branch),
        .target(target),
        .pc(pc),
        .mem_req(mem_req),
        .mem_rdata(mem_rdata),
        .mem_fault(mem_fault),
        .io_address(io_address),
        .io_data_out(io_data_out),
        .io_req(io_req),
        .io_nwr(io_nwr),
        .io_data_in(io_data_in),
        .io_ready(io_ready),
        .hlt(hlt),
        .error(error)
    );

    tiny32_decoder decoder_i (
        .instr(instr),
        .dec(dec)
    );

    tiny32_regfile regfile_i (
        .clk(clk),
        .rs1(dec.rs1),
        .rs2(dec.rs2),
        .rdata1(rs_data1),
        .rdata2(rs_data2),
        .we(rf_we),
        .rd(rf_rd),
        .wdata(rf_wdata)
    );

    tiny32_alu alu_i (
        .a(rs_data1),
        .b(rs_data2),
        .pc(pc),
        .dec(dec),
        .result(alu_result),
        .take_branch(take_branch),
        .target(target)
    );

    tiny32_mem mem_i (
        .clk(clk),
        .req(mem_req),
        .rdata(mem_rdata),
        .fault(mem_fault)
    );

endmodule

/* design/tiny32_control.sv */
`timescale 1ns/1ps

module tiny32_control (
    input  logic                 clk,
    input  logic                 nreset,
    input  tiny32_pkg::decoded_t instr_dec,
    output tiny32_pkg::word_t    instr,
    input  tiny32_pkg::word_t    rs_data1,
    input  tiny32_pkg::word_t    rs_data2,
    output logic                 rf_we,
    output tiny32_pkg::reg_idx_t rf_rd,
    output tiny32_pkg::word_t    rf_wdata,
    input  tiny32_pkg::word_t    alu_result,
    input  logic                 take_branch,
    input  tiny32_pkg::word_t    target,
    output tiny32_pkg::word_t    pc,
    output tiny32_pkg::mem_req_t mem_req,
    input  tiny32_pkg::word_t    mem_rdata,
    input  logic                 mem_fault,
    output tiny32_pkg::word_t    io_address,
    output tiny32_pkg::word_t    io_data_out,
    output logic                 io_req,
    output logic                 io_nwr,
    input  tiny32_pkg::word_t    io_data_in,
    input  logic                 io_ready,
    output logic                 hlt,
    output logic                 error
);
    import tiny32_pkg::*;

    stage_t stage;
    word_t  wb_data;
    word_t  exec_value;
    logic   fetching;

    assign fetching = stage == fetch || stage == fetch_wait;

    // fetch and data access share the one memory port
    always_comb begin
        mem_req = '0;
        mem_req.valid = fetching || stage == mem_addr || stage == mem_wait;
        mem_req.addr = fetching ? pc : alu_result;
        mem_req.size = fetching ? mem_word : instr_dec.mem_size;
        mem_req.is_unsigned = !fetching && instr_dec.is_unsigned;
        mem_req.write_data = rs_data2;
        if (stage == mem_addr && instr_dec.is_store) begin
            case (instr_dec.mem_size)
                mem_byte: mem_req.write_strobe = 4'b0001;
                mem_half: mem_req.write_strobe = 4'b0011;
                default: mem_req.write_strobe = 4'b1111;
            endcase
        end
    end

    // result of instructions that skip memory and io
    always_comb begin
        case (instr_dec.opcode)
            op_lui: exec_value = instr_dec.imm;
            op_auipc: exec_value = pc + instr_dec.imm;
            op_jal, op_jalr: exec_value = pc + 32'd4;
            default: exec_value = alu_result;
        endcase
    end

    assign rf_we = stage == writeback && instr_dec.writes_rd;
    assign rf_rd = instr_dec.rd;
    assign rf_wdata = wb_data;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            stage <= fetch;
            pc <= reset_pc;
            io_req <= 1'b0;
            io_nwr <= 1'b1;
            hlt <= 1'b0;
            error <= 1'b0;
        end else if (!hlt && !error) begin
            case (stage)
                fetch: begin
                    if (mem_fault) begin
                        error <= 1'b1;
                    end else begin
                        stage <= fetch_wait;
                    end
                end
                fetch_wait: begin
                    instr <= mem_rdata;
                    stage <= decode;
                end
                decode: begin
                    if (instr_dec.illegal) begin
                        error <= 1'b1;
                    end else begin
                        stage <= execute;
                    end
                end
                execute: begin
                    if (instr_dec.is_hlt) begin
                        hlt <= 1'b1;
                    end else if (instr_dec.is_load || instr_dec.is_store) begin
                        stage <= mem_addr;
                    end else if (instr_dec.is_in || instr_dec.is_out) begin
                        io_req <= 1'b1;
                        io_address <= rs_data1;
                        io_data_out <= rs_data2;
                        io_nwr <= !instr_dec.is_out;
                        stage <= io_wait;
                    end else begin
                        wb_data <= exec_value;
                        stage <= writeback;
                    end
                end
                mem_addr: begin
                    if (mem_fault) begin
                        error <= 1'b1;
                    end else begin
                        stage <= mem_wait;
                    end
                end
                mem_wait: begin
                    wb_data <= mem_rdata;
                    stage <= writeback;
                end
                io_wait: begin
                    if (io_ready) begin
                        io_req <= 1'b0;
                        wb_data <= io_data_in;
                        stage <= writeback;
                    end
                end
                default: begin
                    pc <= take_branch ? target : pc + 32'd4;
                    stage <= fetch;
                end
            endcase
        end
    end

endmodule

/* design/tiny32_mem.sv */
`timescale 1ns/1ps

module tiny32_mem (
    input  logic                 clk,
    input  tiny32_pkg::mem_req_t req,
    output tiny32_pkg::word_t    rdata,
    output logic                 fault
);
    import tiny32_pkg::*;

    region_t    region;
    logic       rom_sel;
    logic       ram_sel;
    logic       misaligned;
    logic [1:0] offset;
    logic [3:0] lane_we;
    word_t      lane_wdata;
    word_t      rom_q;
    word_t      raw;
    word_t      shifted;
    logic [7:0] lane_q [4];
    word_t      rom [0:(1 << rom_bits)-1];

    initial begin
        $readmemh("testbench/program.hex", rom);
    end

    assign region = region_t'(req.addr[xlen-1:xlen-2]);
    assign rom_sel = region == region_rom;
    assign ram_sel = region == region_ram;
    assign offset = req.addr[1:0];

    assign misaligned = (req.size == mem_half && offset[0])
                        || (req.size == mem_word && offset != 2'd0);
    assign fault = req.valid && (misaligned || !(rom_sel || ram_sel));

    // move store bytes and strobes up to the addressed lane
    assign lane_we = (req.write_strobe << offset) & {4{req.valid && ram_sel && !fault}};
    assign lane_wdata = req.write_data << {offset, 3'b000};

    always_ff @(posedge clk) begin
        rom_q <= rom[req.addr[rom_bits+1:2]];
    end

    for (genvar i = 0; i < 4; i++) begin : g_lane
        tiny32_ram_lane lane_i (
            .clk(clk),
            .addr(req.addr[ram_bits+1:2]),
            .we(lane_we[i]),
            .wdata(lane_wdata[8*i +: 8]),
            .rdata(lane_q[i])
        );
    end

    // request is held through the wait cycle, so its address still selects
    assign raw = rom_sel ? rom_q : {lane_q[3], lane_q[2], lane_q[1], lane_q[0]};
    assign shifted = raw >> {offset, 3'b000};

    always_comb begin
        case (req.size)
            mem_byte: begin
                if (req.is_unsigned) begin
                    rdata = {24'h0, shifted[7:0]};
                end else begin
                    rdata = {{24{shifted[7]}}, shifted[7:0]};
                end
            end
            mem_half: begin
                if (req.is_unsigned) begin
                    rdata = {16'h0, shifted[15:0]};
                end else begin
                    rdata = {{16{shifted[15]}}, shifted[15:0]};
                end
            end
            default: rdata = raw;
        endcase
    end

endmodule

/* design/tiny32_ram_lane.sv */
`timescale 1ns/1ps

module tiny32_ram_lane (
    input  logic                           clk,
    input  logic [tiny32_pkg::ram_bits-1:0] addr,
    input  logic                           we,
    input  logic [7:0]                     wdata,
    output logic [7:0]                     rdata
);
    import tiny32_pkg::*;

    logic [7:0] mem [0:(1 << ram_bits)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

/* design/tiny32_regfile.sv */
`timescale 1ns/1ps

module tiny32_regfile (
    input  logic                 clk,
    input  tiny32_pkg::reg_idx_t rs1,
    input  tiny32_pkg::reg_idx_t rs2,
    output tiny32_pkg::word_t    rdata1,
    output tiny32_pkg::word_t    rdata2,
    input  logic                 we,
    input  tiny32_pkg::reg_idx_t rd,
    input  tiny32_pkg::word_t    wdata
);
    import tiny32_pkg::*;

    word_t regs [0:31];

    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 is never written and reads as zero
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* design/tiny32_alu.sv */
`timescale 1ns/1ps

module tiny32_alu (
    input  tiny32_pkg::word_t    a,
    input  tiny32_pkg::word_t    b,
    input  tiny32_pkg::word_t    pc,
    input  tiny32_pkg::decoded_t dec,
    output tiny32_pkg::word_t    result,
    output logic                 take_branch,
    output tiny32_pkg::word_t    target
);
    import tiny32_pkg::*;

    word_t op2;
    word_t diff;
    logic  carry;
    logic  zero;
    logic  signed_lt;
    logic  cond;

    assign op2 = dec.use_imm ? dec.imm : b;
    // borrow out of the subtraction doubles as unsigned less-than
    assign {carry, diff} = {1'b0, a} - {1'b0, op2};
    assign zero = diff == '0;
    assign signed_lt = (a[xlen-1] != op2[xlen-1]) ? a[xlen-1] : diff[xlen-1];

    always_comb begin
        case (dec.alu_op)
            add: result = a + op2;
            sub: result = diff;
            sll: result = a << op2[4:0];
            srl: result = a >> op2[4:0];
            sra: result = $signed(a) >>> op2[4:0];
            and_op: result = a & op2;
            or_op: result = a | op2;
            xor_op: result = a ^ op2;
            slt: result = {{(xlen-1){1'b0}}, signed_lt};
            sltu: result = {{(xlen-1){1'b0}}, carry};
            default: result = '0;
        endcase
    end

    always_comb begin
        case (dec.func3)
            3'd0: cond = zero;
            3'd1: cond = !zero;
            3'd4: cond = signed_lt;
            3'd5: cond = !signed_lt;
            3'd6: cond = carry;
            default: cond = !carry;
        endcase
    end

    assign take_branch = (dec.opcode == op_branch && cond) || dec.opcode == op_jal
                         || dec.opcode == op_jalr;
    // jalr adds rs1 and imm through the adder and drops bit 0
    assign target = (dec.opcode == op_jalr) ? {result[xlen-1:1], 1'b0} : pc + dec.imm;

endmodule

/* design/tiny32_decoder.sv */
`timescale 1ns/1ps

module tiny32_decoder (
    input  tiny32_pkg::word_t    instr,
    output tiny32_pkg::decoded_t dec
);
    import tiny32_pkg::*;

    logic [2:0] func3;
    logic       alt;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign func3 = instr[14:12];
    // func7 bit 5 selects sub and sra
    assign alt = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt_bit);
        case (f3)
            3'd0: alu_decode = alt_bit ? sub : add;
            3'd1: alu_decode = sll;
            3'd2: alu_decode = slt;
            3'd3: alu_decode = sltu;
            3'd4: alu_decode = xor_op;
            3'd5: alu_decode = alt_bit ? sra : srl;
            3'd6: alu_decode = or_op;
            default: alu_decode = and_op;
        endcase
    endfunction

    always_comb begin
        dec = '0;
        dec.opcode = opcode_t'(instr[6:0]);
        dec.func3 = func3;
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.rd = instr[11:7];
        dec.alu_op = add;
        dec.mem_size = mem_size_t'(func3[1:0]);
        dec.is_unsigned = func3[2];
        case (instr[6:0])
            op_load: begin
                dec.imm = imm_i;
                dec.use_imm = 1'b1;
                dec.is_load = 1'b1;
                dec.writes_rd = 1'b1;
                dec.illegal = func3 inside {3'd3, 3'd6, 3'd7};
            end
            op_store: begin
                dec.imm = imm_s;
                dec.use_imm = 1'b1;
                dec.is_store = 1'b1;
                dec.illegal = func3[2] || func3[1:0] == 2'd3;
            end
            op_alu_imm: begin
                dec.imm = imm_i;
                dec.use_imm = 1'b1;
                dec.writes_rd = 1'b1;
                // addi keeps the sign bit of its immediate in bit 30
                dec.alu_op = alu_decode(func3, alt && func3 == 3'd5);
            end
            op_alu_reg: begin
                dec.writes_rd = 1'b1;
                dec.alu_op = alu_decode(func3, alt);
            end
            op_lui, op_auipc: begin
                dec.imm = imm_u;
                dec.writes_rd = 1'b1;
            end
            op_branch: begin
                dec.imm = imm_b;
                dec.illegal = func3 inside {3'd2, 3'd3};
            end
            op_jalr: begin
                dec.imm = imm_i;
                dec.use_imm = 1'b1;
                dec.writes_rd = 1'b1;
                dec.illegal = func3 != 3'd0;
            end
            op_jal: begin
                dec.imm = imm_j;
                dec.writes_rd = 1'b1;
            end
            op_custom: begin
                dec.is_hlt = func3 == 3'd2;
                dec.is_in = func3 == 3'd3;
                dec.is_out = func3 == 3'd4;
                dec.writes_rd = func3 == 3'd3;
                dec.illegal = !(func3 inside {3'd2, 3'd3, 3'd4});
            end
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

/* design/tiny32_pkg.sv */
package tiny32_pkg;

    localparam int xlen = 32;
    localparam int rom_bits = 10;
    localparam int ram_bits = 10;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] reg_idx_t;

    localparam word_t reset_pc = 32'h40000000;

    // selected by the two top address bits
    typedef enum logic [1:0] {
        region_io_none = 2'd0,
        region_rom     = 2'd1,
        region_ram     = 2'd2
    } region_t;

    typedef enum logic [6:0] {
        op_load    = 7'd3,
        op_custom  = 7'd11,
        op_alu_imm = 7'd19,
        op_auipc   = 7'd23,
        op_store   = 7'd35,
        op_alu_reg = 7'd51,
        op_lui     = 7'd55,
        op_branch  = 7'd99,
        op_jalr    = 7'd103,
        op_jal     = 7'd111
    } opcode_t;

    typedef enum logic [3:0] {
        add, sub, sll, srl, sra,
        and_op, or_op, xor_op, slt, sltu
    } alu_op_t;

    // encoding follows func3[1:0] of loads and stores
    typedef enum logic [1:0] {
        mem_byte = 2'd0,
        mem_half = 2'd1,
        mem_word = 2'd2
    } mem_size_t;

    typedef enum logic [2:0] {
        fetch, fetch_wait, decode, execute,
        mem_addr, mem_wait, io_wait, writeback
    } stage_t;

    typedef struct packed {
        opcode_t   opcode;
        alu_op_t   alu_op;
        logic [2:0] func3;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        word_t     imm;
        logic      use_imm;
        logic      is_load;
        logic      is_store;
        logic      is_unsigned;
        mem_size_t mem_size;
        logic      is_in;
        logic      is_out;
        logic      is_hlt;
        logic      writes_rd;
        logic      illegal;
    } decoded_t;

    typedef struct packed {
        logic       valid;
        word_t      addr;
        logic [3:0] write_strobe;
        word_t      write_data;
        mem_size_t  size;
        logic       is_unsigned;
    } mem_req_t;

endpackage
